/* hw/intr_pkg.sv */
// Shared widths, source ID map and gateway state encoding
// for the system interrupt path

package intr_pkg;

  // Controller source vector
  parameter int NumSrc     = 32;
  parameter int SrcIdWidth = 5;

  // Interrupt lines per peripheral group
  parameter int GpioIntrWidth     = 32;
  parameter int I2cIntrWidth      = 15;
  parameter int UartIntrWidth     = 9;
  parameter int SpiIntrWidth      = 2;
  parameter int UsbdevIntrWidth   = 18;
  parameter int PattgenIntrWidth  = 2;
  parameter int AonTimerIntrWidth = 2;

  // Fixed source positions in the controller vector.
  // IDs not listed here are tied to zero.
  typedef enum logic [SrcIdWidth-1:0] {
    SRC_NONE      = 5'd0,
    SRC_REV_CTL   = 5'd1,
    SRC_USBDEV    = 5'd3,
    SRC_PATTGEN   = 5'd6,
    SRC_AON_TIMER = 5'd7,
    SRC_UART0     = 5'd8,
    SRC_UART1     = 5'd9,
    SRC_I2C0      = 5'd16,
    SRC_I2C1      = 5'd17,
    SRC_SPI0      = 5'd24,
    SRC_SPI1      = 5'd25,
    SRC_GPIO      = 5'd28
  } src_id_e;

  // Per-source gateway
  typedef enum logic {
    GW_OPEN    = 1'b0,
    GW_CLAIMED = 1'b1
  } gw_state_e;

endpackage

/* hw/intr_collect.sv */
// Peripheral interrupt collector
// OR-reduces each interrupt group onto its fixed source ID, registered

module intr_collect
  import intr_pkg::*;
(
  input  logic                         clk_sys_i,
  input  logic                         rst_i,

  // Peripheral interrupt groups
  input  logic [GpioIntrWidth-1:0]     gpio_intr_i,
  input  logic [I2cIntrWidth-1:0]      i2c0_intr_i,
  input  logic [I2cIntrWidth-1:0]      i2c1_intr_i,
  input  logic [UartIntrWidth-1:0]     uart0_intr_i,
  input  logic [UartIntrWidth-1:0]     uart1_intr_i,
  input  logic [SpiIntrWidth-1:0]      spi0_intr_i,
  input  logic [SpiIntrWidth-1:0]      spi1_intr_i,
  input  logic [UsbdevIntrWidth-1:0]   usbdev_intr_i,
  input  logic [PattgenIntrWidth-1:0]  pattgen_intr_i,
  input  logic [AonTimerIntrWidth-1:0] aon_timer_intr_i,
  input  logic                         rev_ctl_intr_i,

  // Source vector to the controller
  output logic [NumSrc-1:0]            src_vec_o
);

  logic [NumSrc-1:0] src_vec_d;
  logic [NumSrc-1:0] src_vec_q;

  // One bit per peripheral, everything else stays zero
  always_comb begin
    src_vec_d = '0;

    src_vec_d[SRC_REV_CTL]   = rev_ctl_intr_i;
    src_vec_d[SRC_USBDEV]    = |usbdev_intr_i;
    src_vec_d[SRC_PATTGEN]   = |pattgen_intr_i;
    src_vec_d[SRC_AON_TIMER] = |aon_timer_intr_i;

    // UARTs
    src_vec_d[SRC_UART0]     = |uart0_intr_i;
    src_vec_d[SRC_UART1]     = |uart1_intr_i;

    // I2C controllers
    src_vec_d[SRC_I2C0]      = |i2c0_intr_i;
    src_vec_d[SRC_I2C1]      = |i2c1_intr_i;

    // SPI hosts
    src_vec_d[SRC_SPI0]      = |spi0_intr_i;
    src_vec_d[SRC_SPI1]      = |spi1_intr_i;

    src_vec_d[SRC_GPIO]      = |gpio_intr_i;
  end

  // One cycle from any group to the vector
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      src_vec_q <= '0;
    end else begin
      src_vec_q <= src_vec_d;
    end
  end

  assign src_vec_o = src_vec_q;

endmodule

/* hw/irq_sync.sv */
// Two-level synchronizer into the system clock
// Carries the timer interrupt and the watchdog bark

module irq_sync #(
  parameter int SyncStages = 2
) (
  input  logic clk_sys_i,
  input  logic rst_i,

  // Asynchronous levels
  input  logic timer_intr_i,
  input  logic wdog_bark_i,

  // Synchronized levels
  output logic timer_sync_o,
  output logic wdog_bark_sync_o
);

  // Bit 0 carries the timer, bit 1 the bark
  logic [SyncStages-1:0][1:0] chain_q;

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      chain_q <= '0;
    end else begin
      chain_q[0] <= {wdog_bark_i, timer_intr_i};
      for (int i = 1; i < SyncStages; i++) begin
        chain_q[i] <= chain_q[i-1];
      end
    end
  end

  // Last stage of each chain
  assign timer_sync_o     = chain_q[SyncStages-1][0];
  assign wdog_bark_sync_o = chain_q[SyncStages-1][1];

endmodule

/* hw/irq_ctrl.sv */
// Small platform interrupt controller
// Level gateways, pending bits, fixed priority, claim and complete,
// plus registered timer and NMI lines to the core

module irq_ctrl
  import intr_pkg::*;
(
  input  logic              clk_sys_i,
  input  logic              rst_i,

  // Sources and mask
  input  logic [NumSrc-1:0] src_vec_i,
  input  logic [NumSrc-1:0] enable_i,

  // Claim takes the current irq_id_o, complete reopens a gateway
  input  logic              claim_i,
  input  logic              complete_i,
  input  src_id_e           complete_id_i,

  // Already synchronized to clk_sys_i
  input  logic              timer_sync_i,
  input  logic              wdog_bark_sync_i,

  // Core interrupt lines
  output logic              irq_o,
  output src_id_e           irq_id_o,
  output logic              irq_timer_o,
  output logic              irq_nm_o
);

  // Gateway and pending state
  gw_state_e         gw_q [NumSrc];
  gw_state_e         gw_d [NumSrc];
  logic [NumSrc-1:0] pending_q;
  logic [NumSrc-1:0] pending_d;

  // Priority select
  logic [NumSrc-1:0] active;
  src_id_e           sel_id;

  // Output registers
  logic              irq_q;
  src_id_e           irq_id_q;
  logic              timer_q;
  logic              nm_q;

  // Next gateway and pending state
  always_comb begin
    pending_d = pending_q;
    for (int i = 0; i < NumSrc; i++) begin
      gw_d[i] = gw_q[i];
    end

    // Open gateways latch a high source
    for (int i = 0; i < NumSrc; i++) begin
      if (gw_q[i] == GW_OPEN && src_vec_i[i]) begin
        pending_d[i] = 1'b1;
      end
    end

    if (complete_i) begin
      gw_d[complete_id_i] = GW_OPEN;
    end

    // Claim of nothing is ignored
    if (claim_i && irq_id_q != SRC_NONE) begin
      pending_d[irq_id_q] = 1'b0;
      gw_d[irq_id_q]      = GW_CLAIMED;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      pending_q <= '0;
      for (int i = 0; i < NumSrc; i++) begin
        gw_q[i] <= GW_OPEN;
      end
    end else begin
      pending_q <= pending_d;
      for (int i = 0; i < NumSrc; i++) begin
        gw_q[i] <= gw_d[i];
      end
    end
  end

  assign active = pending_q & enable_i;

  // Lowest nonzero ID wins; ID 0 is reserved for "none"
  always_comb begin
    sel_id = SRC_NONE;
    for (int i = NumSrc - 1; i > 0; i--) begin
      if (active[i]) begin
        sel_id = src_id_e'(SrcIdWidth'(i));
      end
    end
  end

  // Notification, one cycle behind pending
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      irq_q    <= 1'b0;
      irq_id_q <= SRC_NONE;
    end else begin
      irq_q    <= |active;
      irq_id_q <= sel_id;
    end
  end

  // Timer and bark bypass the gateways
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      timer_q <= 1'b0;
      nm_q    <= 1'b0;
    end else begin
      timer_q <= timer_sync_i;
      nm_q    <= wdog_bark_sync_i;
    end
  end

  assign irq_o       = irq_q;
  assign irq_id_o    = irq_id_q;
  assign irq_timer_o = timer_q;
  assign irq_nm_o    = nm_q;

endmodule

/* hw/intr_top.sv */
// Interrupt path of the system top level
// Collector and controller for peripheral sources, synchronizer for timer and bark

module intr_top
  import intr_pkg::*;
#(
  parameter int SyncStages = 2
) (
  input  logic                         clk_sys_i,
  input  logic                         rst_i,

  // Peripheral interrupt groups
  input  logic [GpioIntrWidth-1:0]     gpio_intr_i,
  input  logic [I2cIntrWidth-1:0]      i2c0_intr_i,
  input  logic [I2cIntrWidth-1:0]      i2c1_intr_i,
  input  logic [UartIntrWidth-1:0]     uart0_intr_i,
  input  logic [UartIntrWidth-1:0]     uart1_intr_i,
  input  logic [SpiIntrWidth-1:0]      spi0_intr_i,
  input  logic [SpiIntrWidth-1:0]      spi1_intr_i,
  input  logic [UsbdevIntrWidth-1:0]   usbdev_intr_i,
  input  logic [PattgenIntrWidth-1:0]  pattgen_intr_i,
  input  logic [AonTimerIntrWidth-1:0] aon_timer_intr_i,
  input  logic                         rev_ctl_intr_i,

  // Asynchronous to clk_sys_i
  input  logic                         timer_intr_i,
  input  logic                         wdog_bark_i,

  // Controller control
  input  logic [NumSrc-1:0]            enable_i,
  input  logic                         claim_i,
  input  logic                         complete_i,
  input  src_id_e                      complete_id_i,

  // To the core
  output logic                         irq_o,
  output src_id_e                      irq_id_o,
  output logic                         irq_timer_o,
  output logic                         irq_nm_o
);

  logic [NumSrc-1:0] src_vec;
  logic              timer_sync;
  logic              wdog_bark_sync;

  intr_collect u_collect (
    .clk_sys_i        (clk_sys_i),
    .rst_i            (rst_i),

    .gpio_intr_i      (gpio_intr_i),
    .i2c0_intr_i      (i2c0_intr_i),
    .i2c1_intr_i      (i2c1_intr_i),
    .uart0_intr_i     (uart0_intr_i),
    .uart1_intr_i     (uart1_intr_i),
    .spi0_intr_i      (spi0_intr_i),
    .spi1_intr_i      (spi1_intr_i),
    .usbdev_intr_i    (usbdev_intr_i),
    .pattgen_intr_i   (pattgen_intr_i),
    .aon_timer_intr_i (aon_timer_intr_i),
    .rev_ctl_intr_i   (rev_ctl_intr_i),

    .src_vec_o        (src_vec)
  );

  // Timer and watchdog bark into the system clock
  irq_sync #(
    .SyncStages(SyncStages)
  ) u_sync (
    .clk_sys_i        (clk_sys_i),
    .rst_i            (rst_i),

    .timer_intr_i     (timer_intr_i),
    .wdog_bark_i      (wdog_bark_i),

    .timer_sync_o     (timer_sync),
    .wdog_bark_sync_o (wdog_bark_sync)
  );

  irq_ctrl u_ctrl (
    .clk_sys_i        (clk_sys_i),
    .rst_i            (rst_i),

    .src_vec_i        (src_vec),
    .enable_i         (enable_i),

    .claim_i          (claim_i),
    .complete_i       (complete_i),
    .complete_id_i    (complete_id_i),

    .timer_sync_i     (timer_sync),
    .wdog_bark_sync_i (wdog_bark_sync),

    .irq_o            (irq_o),
    .irq_id_o         (irq_id_o),
    .irq_timer_o      (irq_timer_o),
    .irq_nm_o         (irq_nm_o)
  );

endmodule

/* bench/tb_intr_top.sv */
// Testbench for the interrupt path top level
// Reference model of gateways, pending bits and sync chains, checked by assertions

module tb_intr_top
  import intr_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int SyncStages = 2;
  localparam int WaitLimit  = 20;
  localparam int NumGroups  = 11;

  logic                         clk = 1'b0;
  logic                         rst;
  logic [GpioIntrWidth-1:0]     gpio_intr;
  logic [I2cIntrWidth-1:0]      i2c0_intr;
  logic [I2cIntrWidth-1:0]      i2c1_intr;
  logic [UartIntrWidth-1:0]     uart0_intr;
  logic [UartIntrWidth-1:0]     uart1_intr;
  logic [SpiIntrWidth-1:0]      spi0_intr;
  logic [SpiIntrWidth-1:0]      spi1_intr;
  logic [UsbdevIntrWidth-1:0]   usbdev_intr;
  logic [PattgenIntrWidth-1:0]  pattgen_intr;
  logic [AonTimerIntrWidth-1:0] aon_timer_intr;
  logic                         rev_ctl_intr;
  logic                         timer_intr;
  logic                         wdog_bark;
  logic [NumSrc-1:0]            enable;
  logic                         claim;
  logic                         complete;
  src_id_e                      complete_id;
  logic                         irq;
  src_id_e                      irq_id;
  logic                         irq_timer;
  logic                         irq_nm;

  int seed       = 30;
  int check_errs = 0;
  int other_errs = 0;

  // Reference model state
  logic [NumSrc-1:0]     m_src;
  logic [NumSrc-1:0]     m_pend;
  gw_state_e             m_gw [NumSrc];
  logic                  m_irq;
  src_id_e               m_id;
  logic [SyncStages-1:0] m_timer_chain;
  logic [SyncStages-1:0] m_bark_chain;
  logic                  m_timer;
  logic                  m_nm;

  always #2 clk = ~clk;

  intr_top #(
    .SyncStages(SyncStages)
  ) i_dut (
    .clk_sys_i        (clk),
    .rst_i            (rst),
    .gpio_intr_i      (gpio_intr),
    .i2c0_intr_i      (i2c0_intr),
    .i2c1_intr_i      (i2c1_intr),
    .uart0_intr_i     (uart0_intr),
    .uart1_intr_i     (uart1_intr),
    .spi0_intr_i      (spi0_intr),
    .spi1_intr_i      (spi1_intr),
    .usbdev_intr_i    (usbdev_intr),
    .pattgen_intr_i   (pattgen_intr),
    .aon_timer_intr_i (aon_timer_intr),
    .rev_ctl_intr_i   (rev_ctl_intr),
    .timer_intr_i     (timer_intr),
    .wdog_bark_i      (wdog_bark),
    .enable_i         (enable),
    .claim_i          (claim),
    .complete_i       (complete),
    .complete_id_i    (complete_id),
    .irq_o            (irq),
    .irq_id_o         (irq_id),
    .irq_timer_o      (irq_timer),
    .irq_nm_o         (irq_nm)
  );

  // Source map of the system top level
  function automatic logic [NumSrc-1:0] expected_src_vec();
    logic [NumSrc-1:0] v;
    v                = '0;
    v[SRC_REV_CTL]   = rev_ctl_intr;
    v[SRC_USBDEV]    = |usbdev_intr;
    v[SRC_PATTGEN]   = |pattgen_intr;
    v[SRC_AON_TIMER] = |aon_timer_intr;
    v[SRC_UART0]     = |uart0_intr;
    v[SRC_UART1]     = |uart1_intr;
    v[SRC_I2C0]      = |i2c0_intr;
    v[SRC_I2C1]      = |i2c1_intr;
    v[SRC_SPI0]      = |spi0_intr;
    v[SRC_SPI1]      = |spi1_intr;
    v[SRC_GPIO]      = |gpio_intr;
    return v;
  endfunction

  // Lowest nonzero ID with its bit set
  function automatic src_id_e lowest_id(logic [NumSrc-1:0] vec);
    for (int i = 1; i < NumSrc; i++) begin
      if (vec[i]) begin
        return src_id_e'(SrcIdWidth'(i));
      end
    end
    return SRC_NONE;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      m_src         <= '0;
      m_pend        <= '0;
      m_irq         <= 1'b0;
      m_id          <= SRC_NONE;
      m_timer_chain <= '0;
      m_bark_chain  <= '0;
      m_timer       <= 1'b0;
      m_nm          <= 1'b0;
      for (int i = 0; i < NumSrc; i++) begin
        m_gw[i] <= GW_OPEN;
      end
    end else begin
      m_src <= expected_src_vec();
      for (int i = 0; i < NumSrc; i++) begin
        if (claim && m_id != SRC_NONE && int'(m_id) == i) begin
          m_pend[i] <= 1'b0;
          m_gw[i]   <= GW_CLAIMED;
        end else begin
          if (complete && int'(complete_id) == i) begin
            m_gw[i] <= GW_OPEN;
          end
          if (m_gw[i] == GW_OPEN && m_src[i]) begin
            m_pend[i] <= 1'b1;
          end
        end
      end
      m_irq         <= |(m_pend & enable);
      m_id          <= lowest_id(m_pend & enable);
      m_timer_chain <= {m_timer_chain[SyncStages-2:0], timer_intr};
      m_bark_chain  <= {m_bark_chain[SyncStages-2:0], wdog_bark};
      m_timer       <= m_timer_chain[SyncStages-1];
      m_nm          <= m_bark_chain[SyncStages-1];
    end
  end

  task automatic report_mismatch(string name, int dut_val, int exp_val);
    check_errs++;
    $display("CHECK FAILED at %0t ns: %s dut=%0d expected=%0d",
             $time, name, dut_val, exp_val);
  endtask

  task automatic report_timeout(string what);
    other_errs++;
    $display("Timeout: %s did not happen within %0d cycles", what, WaitLimit);
  endtask

  // Cycle by cycle against the model
  a_irq: assert property (@(posedge clk) disable iff (rst) irq == m_irq)
    else report_mismatch("irq_o", int'($sampled(irq)), int'($sampled(m_irq)));
  a_irq_id: assert property (@(posedge clk) disable iff (rst) irq_id == m_id)
    else report_mismatch("irq_id_o", int'($sampled(irq_id)), int'($sampled(m_id)));
  a_timer: assert property (@(posedge clk) disable iff (rst) irq_timer == m_timer)
    else report_mismatch("irq_timer_o", int'($sampled(irq_timer)), int'($sampled(m_timer)));
  a_nm: assert property (@(posedge clk) disable iff (rst) irq_nm == m_nm)
    else report_mismatch("irq_nm_o", int'($sampled(irq_nm)), int'($sampled(m_nm)));

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_groups();
    gpio_intr      = '0;
    i2c0_intr      = '0;
    i2c1_intr      = '0;
    uart0_intr     = '0;
    uart1_intr     = '0;
    spi0_intr      = '0;
    spi1_intr      = '0;
    usbdev_intr    = '0;
    pattgen_intr   = '0;
    aon_timer_intr = '0;
    rev_ctl_intr   = 1'b0;
  endtask

  function automatic int group_width(int g);
    case (g)
      0:       return 1;
      1:       return UsbdevIntrWidth;
      2:       return PattgenIntrWidth;
      3:       return AonTimerIntrWidth;
      4, 5:    return UartIntrWidth;
      6, 7:    return I2cIntrWidth;
      8, 9:    return SpiIntrWidth;
      default: return GpioIntrWidth;
    endcase
  endfunction

  function automatic src_id_e group_id(int g);
    case (g)
      0:       return SRC_REV_CTL;
      1:       return SRC_USBDEV;
      2:       return SRC_PATTGEN;
      3:       return SRC_AON_TIMER;
      4:       return SRC_UART0;
      5:       return SRC_UART1;
      6:       return SRC_I2C0;
      7:       return SRC_I2C1;
      8:       return SRC_SPI0;
      9:       return SRC_SPI1;
      default: return SRC_GPIO;
    endcase
  endfunction

  // One random line of a group goes high
  task automatic drive_group(int g);
    logic [31:0] onehot;
    onehot = 32'd1 << ($unsigned($random(seed)) % group_width(g));
    case (g)
      0:       rev_ctl_intr   = 1'b1;
      1:       usbdev_intr    = onehot[UsbdevIntrWidth-1:0];
      2:       pattgen_intr   = onehot[PattgenIntrWidth-1:0];
      3:       aon_timer_intr = onehot[AonTimerIntrWidth-1:0];
      4:       uart0_intr     = onehot[UartIntrWidth-1:0];
      5:       uart1_intr     = onehot[UartIntrWidth-1:0];
      6:       i2c0_intr      = onehot[I2cIntrWidth-1:0];
      7:       i2c1_intr      = onehot[I2cIntrWidth-1:0];
      8:       spi0_intr      = onehot[SpiIntrWidth-1:0];
      9:       spi1_intr      = onehot[SpiIntrWidth-1:0];
      default: gpio_intr      = onehot[GpioIntrWidth-1:0];
    endcase
  endtask

  // exp_lat of 0 skips the latency check
  task automatic wait_for_irq(src_id_e exp_id, int exp_lat);
    int n;
    n = 0;
    while (!irq && n < WaitLimit) begin
      step();
      n++;
    end
    if (!irq) begin
      report_timeout("rise of irq_o");
    end else begin
      assert (irq_id == exp_id) else report_mismatch("irq_id_o", int'(irq_id), int'(exp_id));
      if (exp_lat > 0) begin
        assert (n == exp_lat) else report_mismatch("irq_o latency", n, exp_lat);
      end
    end
  endtask

  task automatic claim_and_expect(src_id_e exp_next);
    src_id_e taken;
    int      n;
    taken = irq_id;
    claim = 1'b1;
    step();
    claim = 1'b0;
    n     = 1;
    while (irq_id == taken && n < WaitLimit) begin
      step();
      n++;
    end
    if (irq_id == taken) begin
      report_timeout("change of irq_id_o after claim");
    end else begin
      assert (irq_id == exp_next) else report_mismatch("irq_id_o", int'(irq_id), int'(exp_next));
      assert (n == 2) else report_mismatch("claim to next irq_id_o latency", n, 2);
    end
  endtask

  task automatic complete_pulse(src_id_e id);
    complete_id = id;
    complete    = 1'b1;
    step();
    complete    = 1'b0;
  endtask

  task automatic expect_no_irq(int cycles);
    repeat (cycles) begin
      step();
      assert (!irq) else report_mismatch("irq_o", 1, 0);
      assert (irq_id == SRC_NONE) else report_mismatch("irq_id_o", int'(irq_id), 0);
    end
  endtask

  task automatic wait_core_lines(logic exp_timer, logic exp_nm);
    int n;
    n = 0;
    while ((irq_timer != exp_timer || irq_nm != exp_nm) && n < WaitLimit) begin
      step();
      n++;
    end
    if (irq_timer != exp_timer || irq_nm != exp_nm) begin
      report_timeout("change of irq_timer_o or irq_nm_o");
    end else begin
      assert (n == SyncStages + 1) else report_mismatch("core line latency", n, SyncStages + 1);
    end
  endtask

  initial begin
    src_id_e order [5];
    order = '{SRC_USBDEV, SRC_UART1, SRC_I2C0, SRC_SPI1, SRC_GPIO};

    clear_groups();
    timer_intr  = 1'b0;
    wdog_bark   = 1'b0;
    enable      = '1;
    claim       = 1'b0;
    complete    = 1'b0;
    complete_id = SRC_NONE;
    rst         = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    // Quiet after reset
    expect_no_irq(4);

    // Each group on its own
    for (int g = 0; g < NumGroups; g++) begin
      drive_group(g);
      wait_for_irq(group_id(g), 3);
      clear_groups();
      claim_and_expect(SRC_NONE);
      complete_pulse(group_id(g));
    end

    // Masked source stays pending
    enable[SRC_GPIO] = 1'b0;
    drive_group(10);
    expect_no_irq(8);
    enable[SRC_GPIO] = 1'b1;
    wait_for_irq(SRC_GPIO, 1);
    clear_groups();
    claim_and_expect(SRC_NONE);
    complete_pulse(SRC_GPIO);

    // Several sources, claimed in priority order and held high
    drive_group(1);
    drive_group(5);
    drive_group(6);
    drive_group(9);
    drive_group(10);
    wait_for_irq(SRC_USBDEV, 3);
    for (int i = 1; i < 5; i++) begin
      claim_and_expect(order[i]);
    end
    claim_and_expect(SRC_NONE);
    expect_no_irq(8);
    complete_pulse(SRC_I2C0);
    wait_for_irq(SRC_I2C0, 2);
    claim_and_expect(SRC_NONE);
    clear_groups();
    step();
    step();
    for (int i = 0; i < 5; i++) begin
      complete_pulse(order[i]);
    end
    expect_no_irq(6);

    // Claim of no ID while a masked source is pending
    enable[SRC_SPI0] = 1'b0;
    drive_group(8);
    expect_no_irq(4);
    claim = 1'b1;
    step();
    claim = 1'b0;
    expect_no_irq(3);
    enable[SRC_SPI0] = 1'b1;
    wait_for_irq(SRC_SPI0, 1);
    clear_groups();
    claim_and_expect(SRC_NONE);
    complete_pulse(SRC_SPI0);
    expect_no_irq(3);

    // Timer and bark, with a peripheral source active alongside
    drive_group(4);
    timer_intr = 1'b1;
    wait_core_lines(1'b1, 1'b0);
    wdog_bark = 1'b1;
    wait_core_lines(1'b1, 1'b1);
    timer_intr = 1'b0;
    wait_core_lines(1'b0, 1'b1);
    wdog_bark = 1'b0;
    wait_core_lines(1'b0, 1'b0);
    wait_for_irq(SRC_UART0, 0);
    clear_groups();
    claim_and_expect(SRC_NONE);
    complete_pulse(SRC_UART0);
    expect_no_irq(4);

    $display("Errors: %0d check, %0d other", check_errs, other_errs);
    if (check_errs == 0 && other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
hw/intr_pkg.sv
hw/intr_collect.sv
hw/irq_sync.sv
hw/irq_ctrl.sv
hw/intr_top.sv
bench/tb_intr_top.sv

/* Makefile */
# Verilator build and run of the interrupt path testbench

SRCS := $(wildcard hw/*.sv bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_intr_top: tb.f $(SRCS)
	verilator --binary --timing --assert -f tb.f --top-module tb_intr_top \
		-Mdir obj_dir -o Vtb_intr_top

sim.log: obj_dir/Vtb_intr_top
	./obj_dir/Vtb_intr_top > sim.log 2>&1 || true

run: sim.log
	@cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
